/* files.f */
rtl/bus_if_pkg.sv
rtl/bus_cycle_ctrl.sv
rtl/write_data_align.sv
rtl/read_byte_lane.sv
rtl/read_data_buffer.sv
rtl/bus_interface_top.sv
verification/bus_interface_checker.sv
verification/bus_interface_tb.sv

/* rtl/bus_cycle_ctrl.sv */
/*
 * Bus cycle FSM with dynamic bus sizing: remaining-size countdown,
 * address offset, strobe decode and capture pulses for the data path.
 */
module bus_cycle_ctrl (
    input  logic                    CLK,
    input  logic                    RESET_CPU_I,
    input  logic                    rd_req,
    input  logic                    wr_req,
    input  bus_if_pkg::op_size_t    op_size,
    input  bus_if_pkg::addr_t       adr_in,
    input  bus_if_pkg::dsack_t      dsack_n,
    output bus_if_pkg::addr_t       adr_out,
    output bus_if_pkg::size_code_t  size,
    output logic [1:0]              adr_10,
    output bus_if_pkg::port_width_t port_width,
    output logic                    as_n,
    output logic                    ds_n,
    output logic                    dben_n,
    output logic                    rw_n,
    output logic                    data_port_en,
    output logic                    bus_bsy,
    output logic                    wbuf_load,
    output logic                    lane_capture,
    output logic                    xfer_done,
    output logic                    done_is_read
);

    bus_if_pkg::bus_state_e state;
    bus_if_pkg::bus_state_e state_nxt;
    bus_if_pkg::dsack_t     dsack_q;        // Registered acknowledge.
    bus_if_pkg::xfer_cnt_t  remain_cnt;     // Bytes still to move.
    bus_if_pkg::xfer_cnt_t  adr_offset;     // Bytes already moved.
    bus_if_pkg::xfer_cnt_t  init_cnt;
    bus_if_pkg::xfer_cnt_t  moved;
    bus_if_pkg::xfer_cnt_t  cnt_nxt;
    logic                   is_write;
    logic                   done_q;
    logic                   start_req;
    logic                   ack_seen;

    // ----------------------------------------
    // Transfer bookkeeping.
    // ----------------------------------------
    always_comb begin
        case (op_size)
            bus_if_pkg::OP_BYTE: init_cnt = 3'd1;
            bus_if_pkg::OP_WORD: init_cnt = 3'd2;
            bus_if_pkg::OP_LONG: init_cnt = 3'd4;
            default:             init_cnt = 3'd4;   // Unused code, treated as long.
        endcase
    end

    assign moved    = bus_if_pkg::xfer_len(port_width, size, adr_10);
    assign cnt_nxt  = remain_cnt - moved;
    assign ack_seen = (dsack_q != bus_if_pkg::DSACK_NONE);

    // The clock after data_rdy still shows the old request, so hold off one clock.
    assign start_req = (rd_req || wr_req) && !done_q;

    assign adr_out = adr_in + bus_if_pkg::addr_t'(adr_offset);
    assign adr_10  = adr_out[1:0];
    assign size    = remain_cnt[1:0];   // Count of 4 shows as 00.

    // ----------------------------------------
    // State machine.
    // ----------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            bus_if_pkg::BUS_IDLE: begin
                if (start_req)
                    state_nxt = bus_if_pkg::START_CYCLE;
            end
            bus_if_pkg::START_CYCLE:
                state_nxt = bus_if_pkg::ADDR_PHASE;
            bus_if_pkg::ADDR_PHASE:
                state_nxt = bus_if_pkg::WAIT_PHASE;
            bus_if_pkg::WAIT_PHASE: begin
                if (ack_seen)
                    state_nxt = bus_if_pkg::DATA_PHASE;
            end
            bus_if_pkg::DATA_PHASE: begin
                if (cnt_nxt == 3'd0)
                    state_nxt = bus_if_pkg::BUS_IDLE;
                else
                    state_nxt = bus_if_pkg::ADDR_PHASE;   // Next port cycle.
            end
            default:
                state_nxt = bus_if_pkg::BUS_IDLE;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET_CPU_I) begin
            state      <= bus_if_pkg::BUS_IDLE;
            dsack_q    <= bus_if_pkg::DSACK_NONE;
            port_width <= bus_if_pkg::PORT_32;
            remain_cnt <= 3'd0;
            adr_offset <= 3'd0;
            is_write   <= 1'b0;
            done_q     <= 1'b0;
        end else begin
            state  <= state_nxt;
            done_q <= xfer_done;

            // Sampled only while waiting, so an old acknowledge is not seen twice.
            if (state == bus_if_pkg::WAIT_PHASE)
                dsack_q <= dsack_n;
            else
                dsack_q <= bus_if_pkg::DSACK_NONE;

            if (wbuf_load) begin
                remain_cnt <= init_cnt;
                adr_offset <= 3'd0;
                is_write   <= !rd_req;          // Reads win a tie.
            end else if (state == bus_if_pkg::DATA_PHASE) begin
                remain_cnt <= cnt_nxt;
                adr_offset <= adr_offset + moved;
            end

            // Port width holds for the data phase of this port cycle.
            if (state == bus_if_pkg::WAIT_PHASE && ack_seen) begin
                case (dsack_q)
                    bus_if_pkg::DSACK_16: port_width <= bus_if_pkg::PORT_16;
                    bus_if_pkg::DSACK_8:  port_width <= bus_if_pkg::PORT_8;
                    default:              port_width <= bus_if_pkg::PORT_32;
                endcase
            end
        end
    end

    // ----------------------------------------
    // Strobes and data path pulses.
    // ----------------------------------------
    assign bus_bsy = (state != bus_if_pkg::BUS_IDLE);

    assign as_n = !(state == bus_if_pkg::ADDR_PHASE ||
                    state == bus_if_pkg::WAIT_PHASE ||
                    state == bus_if_pkg::DATA_PHASE);

    assign dben_n = !(state == bus_if_pkg::WAIT_PHASE ||
                      state == bus_if_pkg::DATA_PHASE);

    assign ds_n         = is_write ? dben_n : as_n;   // Late data strobe on writes.
    assign rw_n         = !(is_write && bus_bsy);
    assign data_port_en = is_write && bus_bsy;

    assign wbuf_load    = (state == bus_if_pkg::BUS_IDLE) && start_req;
    assign lane_capture = (state == bus_if_pkg::DATA_PHASE) && !is_write;
    assign xfer_done    = (state == bus_if_pkg::DATA_PHASE) && (cnt_nxt == 3'd0);
    assign done_is_read = !is_write;

endmodule

/* rtl/bus_if_pkg.sv */
/*
 * Bus types, operand size and port-width codes, controller states and the
 * transfer-length helpers shared by the bus interface blocks.
 */
package bus_if_pkg;

    typedef logic [31:0] addr_t;        // Byte address.
    typedef logic [31:0] data_t;        // Operand and port data.
    typedef logic [7:0]  port_byte_t;   // One byte lane.
    typedef logic [1:0]  op_size_t;     // Operand size from the core.
    typedef logic [1:0]  size_code_t;   // SIZE pins, four bytes show as 00.
    typedef logic [2:0]  xfer_cnt_t;    // Bytes still to move, 0 to 4.
    typedef logic [1:0]  port_width_t;  // Width of the responding port.
    typedef logic [1:0]  dsack_t;       // DSACK1/DSACK0, active low.

    // Operand sizes.
    localparam op_size_t OP_BYTE = 2'b01;
    localparam op_size_t OP_WORD = 2'b10;
    localparam op_size_t OP_LONG = 2'b00;

    // Port widths.
    localparam port_width_t PORT_32 = 2'b00;
    localparam port_width_t PORT_16 = 2'b01;
    localparam port_width_t PORT_8  = 2'b10;

    // Acknowledge codes.
    localparam dsack_t DSACK_32   = 2'b00;
    localparam dsack_t DSACK_16   = 2'b01;
    localparam dsack_t DSACK_8    = 2'b10;
    localparam dsack_t DSACK_NONE = 2'b11;  // Wait state.

    localparam int NUM_LANES = 4;

    typedef enum logic [2:0] {
        BUS_IDLE,
        START_CYCLE,
        ADDR_PHASE,
        WAIT_PHASE,
        DATA_PHASE
    } bus_state_e;

    // Remaining byte count from the SIZE code.
    function automatic xfer_cnt_t size_bytes(size_code_t size);
        return (size == 2'b00) ? 3'd4 : {1'b0, size};
    endfunction

    // Bytes moved by one port cycle: up to the port edge, never past the remainder.
    function automatic xfer_cnt_t xfer_len(port_width_t width, size_code_t size,
                                           logic [1:0] adr);
        xfer_cnt_t remain;
        xfer_cnt_t edge_cnt;
        remain = size_bytes(size);
        case (width)
            PORT_32: edge_cnt = 3'd4 - {1'b0, adr};
            PORT_16: edge_cnt = 3'd2 - {2'b00, adr[0]};
            default: edge_cnt = 3'd1;   // 8 bit port.
        endcase
        return (edge_cnt < remain) ? edge_cnt : remain;
    endfunction

endpackage

/* rtl/bus_interface_top.sv */
/*
 * Bus interface top level: cycle controller, write aligner, read byte lanes
 * and read data buffer.
 */
module bus_interface_top (
    input  logic                   CLK,
    input  logic                   RESET_CPU_I,
    input  logic                   rd_req,
    input  logic                   wr_req,
    input  bus_if_pkg::op_size_t   op_size,
    input  bus_if_pkg::addr_t      adr_in,
    input  bus_if_pkg::data_t      data_from_core,
    input  bus_if_pkg::data_t      data_port_in,
    input  bus_if_pkg::dsack_t     dsack_n,
    output bus_if_pkg::addr_t      adr_out,
    output bus_if_pkg::size_code_t size,
    output bus_if_pkg::data_t      data_port_out,
    output logic                   data_port_en,
    output bus_if_pkg::data_t      data_to_core,
    output logic                   data_rdy,
    output logic                   as_n,
    output logic                   ds_n,
    output logic                   dben_n,
    output logic                   rw_n,
    output logic                   bus_bsy
);

    logic [1:0]              adr_10;
    bus_if_pkg::port_width_t port_width;
    logic                    wbuf_load;
    logic                    lane_capture;
    logic                    xfer_done;
    logic                    done_is_read;
    bus_if_pkg::data_t       lane_bytes;    // Operand bytes gathered so far.

    // ----------------------------------------
    // Cycle controller.
    // ----------------------------------------
    bus_cycle_ctrl u_ctrl (
        .CLK          (CLK),
        .RESET_CPU_I  (RESET_CPU_I),
        .rd_req       (rd_req),
        .wr_req       (wr_req),
        .op_size      (op_size),
        .adr_in       (adr_in),
        .dsack_n      (dsack_n),
        .adr_out      (adr_out),
        .size         (size),
        .adr_10       (adr_10),
        .port_width   (port_width),
        .as_n         (as_n),
        .ds_n         (ds_n),
        .dben_n       (dben_n),
        .rw_n         (rw_n),
        .data_port_en (data_port_en),
        .bus_bsy      (bus_bsy),
        .wbuf_load    (wbuf_load),
        .lane_capture (lane_capture),
        .xfer_done    (xfer_done),
        .done_is_read (done_is_read)
    );

    // ----------------------------------------
    // Write path.
    // ----------------------------------------
    write_data_align u_wr_align (
        .CLK            (CLK),
        .wbuf_load      (wbuf_load),
        .data_from_core (data_from_core),
        .size           (size),
        .adr_low        (adr_10),
        .data_port_out  (data_port_out)
    );

    // ----------------------------------------
    // Read path.
    // ----------------------------------------
    for (genvar i = 0; i < bus_if_pkg::NUM_LANES; i++) begin : g_lane
        read_byte_lane #(
            .LANE (i)
        ) u_lane (
            .CLK          (CLK),
            .RESET_CPU_I  (RESET_CPU_I),
            .lane_capture (lane_capture),
            .port_width   (port_width),
            .size         (size),
            .adr_10       (adr_10),
            .data_port_in (data_port_in),
            .lane_byte    (lane_bytes[8*i +: 8])
        );
    end

    read_data_buffer u_rd_buf (
        .CLK          (CLK),
        .RESET_CPU_I  (RESET_CPU_I),
        .xfer_done    (xfer_done),
        .done_is_read (done_is_read),
        .op_size      (op_size),
        .lane_bytes   (lane_bytes),
        .data_to_core (data_to_core),
        .data_rdy     (data_rdy)
    );

endmodule

/* rtl/read_byte_lane.sv */
/*
 * One operand byte of the read path with its port byte select.
 */
module read_byte_lane #(
    parameter int LANE = 0                  // Operand byte, 0 is the least significant.
) (
    input  logic                    CLK,
    input  logic                    RESET_CPU_I,
    input  logic                    lane_capture,
    input  bus_if_pkg::port_width_t port_width,
    input  bus_if_pkg::size_code_t  size,
    input  logic [1:0]              adr_10,
    input  bus_if_pkg::data_t       data_port_in,
    output bus_if_pkg::port_byte_t  lane_byte
);

    localparam bus_if_pkg::xfer_cnt_t LANE_POS = bus_if_pkg::xfer_cnt_t'(LANE);

    bus_if_pkg::xfer_cnt_t  remain;
    bus_if_pkg::xfer_cnt_t  moved;
    logic                   hit;
    logic [1:0]             byte_adr;   // Address bits of this byte in the cycle.
    logic [1:0]             src_lane;   // 3 is D31:24.
    bus_if_pkg::port_byte_t src_byte;

    assign remain = bus_if_pkg::size_bytes(size);
    assign moved  = bus_if_pkg::xfer_len(port_width, size, adr_10);

    // Byte k of the cycle lands in operand byte remain-1-k.
    assign hit      = (remain > LANE_POS) && ((remain - LANE_POS) <= moved);
    assign byte_adr = adr_10 + 2'(remain - LANE_POS - 3'd1);

    always_comb begin
        case (port_width)
            bus_if_pkg::PORT_32: src_lane = 2'd3 - byte_adr;
            bus_if_pkg::PORT_16: src_lane = byte_adr[0] ? 2'd2 : 2'd3;
            default:             src_lane = 2'd3;  // 8 bit port on D31:24.
        endcase
    end

    assign src_byte = data_port_in[{src_lane, 3'b000} +: 8];

    always_ff @(posedge CLK) begin
        if (RESET_CPU_I)
            lane_byte <= '0;
        else if (lane_capture && hit)
            lane_byte <= src_byte;  // Held until a later cycle fills it again.
    end

endmodule

/* rtl/read_data_buffer.sv */
/*
 * Read data buffer: zero extension by operand size and the data_rdy strobe.
 */
module read_data_buffer (
    input  logic                 CLK,
    input  logic                 RESET_CPU_I,
    input  logic                 xfer_done,
    input  logic                 done_is_read,
    input  bus_if_pkg::op_size_t op_size,
    input  bus_if_pkg::data_t    lane_bytes,
    output bus_if_pkg::data_t    data_to_core,
    output logic                 data_rdy
);

    bus_if_pkg::op_size_t rd_size;      // Size of the finished read.
    logic                 rd_load;      // Lanes hold the new word this clock.
    bus_if_pkg::data_t    word_ext;
    bus_if_pkg::data_t    dbuf;

    always_comb begin
        case (rd_size)
            bus_if_pkg::OP_BYTE: word_ext = {24'h0, lane_bytes[7:0]};
            bus_if_pkg::OP_WORD: word_ext = {16'h0, lane_bytes[15:0]};
            default:             word_ext = lane_bytes;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET_CPU_I) begin
            data_rdy <= 1'b0;
            rd_load  <= 1'b0;
        end else begin
            data_rdy <= xfer_done;      // Strobe, reads and writes alike.
            rd_load  <= xfer_done && done_is_read;
        end
    end

    always_ff @(posedge CLK) begin
        if (xfer_done && done_is_read)
            rd_size <= op_size;
        if (rd_load)
            dbuf <= word_ext;
    end

    // The last lane byte lands with data_rdy, so pass it straight through then.
    assign data_to_core = rd_load ? word_ext : dbuf;

endmodule

/* rtl/write_data_align.sv */
/*
 * Write data latch and byte-lane replication onto the data port.
 */
module write_data_align (
    input  logic                   CLK,
    input  logic                   wbuf_load,
    input  bus_if_pkg::data_t      data_from_core,
    input  bus_if_pkg::size_code_t size,
    input  logic [1:0]             adr_low,
    output bus_if_pkg::data_t      data_port_out
);

    bus_if_pkg::data_t      wbuf;       // Core data held for the whole transfer.
    bus_if_pkg::data_t      aligned;
    logic [1:0]             skip;       // Bytes already sent.
    bus_if_pkg::port_byte_t b0;
    bus_if_pkg::port_byte_t b1;
    bus_if_pkg::port_byte_t b2;
    bus_if_pkg::port_byte_t b3;

    always_ff @(posedge CLK) begin
        if (wbuf_load)
            wbuf <= data_from_core;
    end

    // Shift the unsent bytes to the top, b0 is the next byte to go out.
    assign skip    = 2'd0 - size;
    assign aligned = wbuf << {skip, 3'b000};

    assign b0 = aligned[31:24];
    assign b1 = aligned[23:16];
    assign b2 = aligned[15:8];
    assign b3 = aligned[7:0];

    // ----------------------------------------
    // 68030 lane replication.
    // ----------------------------------------
    // A 16 bit port reads D31:16 and an 8 bit port reads D31:24, so the
    // upper lanes repeat what a narrow port expects at this address.
    always_comb begin
        case ({size, adr_low})
            // Four bytes left.
            4'b00_00: data_port_out = {b0, b1, b2, b3};
            4'b00_01: data_port_out = {b0, b0, b1, b2};
            4'b00_10: data_port_out = {b0, b1, b0, b1};
            4'b00_11: data_port_out = {b0, b0, b1, b0};
            // Three bytes left.
            4'b11_00: data_port_out = {b0, b1, b2, b0};
            4'b11_01: data_port_out = {b0, b0, b1, b2};
            4'b11_10: data_port_out = {b0, b1, b0, b1};
            4'b11_11: data_port_out = {b0, b0, b1, b0};
            // Two bytes left.
            4'b10_00: data_port_out = {b0, b1, b0, b1};
            4'b10_01: data_port_out = {b0, b0, b1, b0};
            4'b10_10: data_port_out = {b0, b1, b0, b1};
            4'b10_11: data_port_out = {b0, b0, b1, b0};
            default:  data_port_out = {4{b0}};   // Single byte on every lane.
        endcase
    end

endmodule

/* verification/bus_interface_checker.sv */
/*
 * Concurrent assertions on the bus cycle controller strobes.
 */
module bus_interface_checker (
    input logic CLK,
    input logic RESET_CPU_I,
    input logic as_n,
    input logic ds_n,
    input logic rw_n,
    input logic bus_bsy,
    input logic xfer_done
);
    timeunit 1ns;
    timeprecision 100ps;

    // ----------------------------------------
    // Strobe rules.
    // ----------------------------------------
    // Data strobe only inside an address strobe.
    a_ds_inside_as: assert property (
        @(posedge CLK) disable iff (RESET_CPU_I)
        !ds_n |-> !as_n
    ) else $error("ds_n asserted while as_n is high");

    // Direction holds for the whole transfer.
    a_rw_stable: assert property (
        @(posedge CLK) disable iff (RESET_CPU_I)
        (bus_bsy && $past(bus_bsy)) |-> $stable(rw_n)
    ) else $error("rw_n changed during a busy transfer");

    // data_rdy follows xfer_done by one clock, so the bus must be released then.
    a_rdy_after_as: assert property (
        @(posedge CLK) disable iff (RESET_CPU_I)
        xfer_done |=> as_n
    ) else $error("data_rdy pulsed while as_n is low");

endmodule

bind bus_cycle_ctrl bus_interface_checker u_chk (
    .CLK         (CLK),
    .RESET_CPU_I (RESET_CPU_I),
    .as_n        (as_n),
    .ds_n        (ds_n),
    .rw_n        (rw_n),
    .bus_bsy     (bus_bsy),
    .xfer_done   (xfer_done)
);

/* verification/bus_interface_tb.sv */
/*
 * Table-driven testbench for the bus interface: sized memory model,
 * compare tasks, reset checks and a watchdog.
 */
module bus_interface_tb;
    timeunit 1ns;
    timeprecision 100ps;

    typedef struct {
        bit                      wr;
        bus_if_pkg::addr_t       adr;
        bus_if_pkg::op_size_t    sz;
        bus_if_pkg::data_t       wdata;
        bus_if_pkg::port_width_t pw;
        int                      waits;
        bus_if_pkg::data_t       exp;
        int                      cycles;
    } entry_t;

    logic CLK = 1'b0;
    logic RESET_CPU_I, rd_req, wr_req;
    bus_if_pkg::op_size_t   op_size;
    bus_if_pkg::addr_t      adr_in, adr_out;
    bus_if_pkg::data_t      data_from_core, data_port_in, data_port_out, data_to_core;
    bus_if_pkg::dsack_t     dsack_n;
    bus_if_pkg::size_code_t size;
    logic data_port_en, data_rdy, as_n, ds_n, dben_n, rw_n, bus_bsy;

    entry_t                  table_q[$];
    bus_if_pkg::port_byte_t  mem [64];      // Device memory.
    bus_if_pkg::port_byte_t  ref_mem [64];  // Expected memory image.
    bus_if_pkg::port_width_t cur_pw;
    bit cur_wr;                             // Access type of the current entry.
    int cur_waits, wcnt, port_cycles;
    bit acked;
    int seed = 32'h625d;
    int data_errs = 0, count_errs = 0, bit_errs = 0;

    bus_interface_top dut0 (.*);

    always #2 CLK = ~CLK;

    // ----------------------------------------
    // Compare tasks.
    // ----------------------------------------
    task automatic check_data(string name, bus_if_pkg::data_t got, bus_if_pkg::data_t exp);
        if (got !== exp) begin
            $display("Fail t=%0t %s got=%h exp=%h", $time, name, got, exp);
            data_errs++;
        end
    endtask

    task automatic check_count(string name, int got, int exp);
        if (got != exp) begin
            $display("Fail t=%0t %s got=%0d exp=%0d", $time, name, got, exp);
            count_errs++;
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("Fail t=%0t %s got=%b exp=%b", $time, name, got, exp);
            bit_errs++;
        end
    endtask

    // Bytes one port cycle moves, by the port edge and the remainder.
    function automatic int cycle_bytes(bus_if_pkg::port_width_t pw, logic [1:0] a,
                                       bus_if_pkg::size_code_t sz);
        int remain;
        int lim;
        remain = (sz == 2'b00) ? 4 : int'(sz);
        if (pw == bus_if_pkg::PORT_32)
            lim = 4 - int'(a);
        else if (pw == bus_if_pkg::PORT_16)
            lim = 2 - int'(a[0]);
        else
            lim = 1;
        return (lim < remain) ? lim : remain;
    endfunction

    // Port lane of a byte address, 3 is D31:24.
    function automatic int port_lane(bus_if_pkg::port_width_t pw, logic [1:0] a);
        if (pw == bus_if_pkg::PORT_32)
            return 3 - int'(a);
        else if (pw == bus_if_pkg::PORT_16)
            return a[0] ? 2 : 3;
        return 3;
    endfunction

    // ----------------------------------------
    // Memory model, answers as cur_pw.
    // ----------------------------------------
    task automatic respond();
        int n;
        int ln;
        logic [5:0] a;
        bus_if_pkg::data_t word;
        word = '0;
        check_bit("ds_n", ds_n, 1'b0);
        check_bit("rw_n", rw_n, !cur_wr);
        check_bit("data_port_en", data_port_en, cur_wr);
        n = cycle_bytes(cur_pw, adr_out[1:0], size);
        for (int k = 0; k < n; k++) begin
            a = adr_out[5:0] + 6'(k);
            ln = port_lane(cur_pw, a[1:0]);
            if (!rw_n)
                mem[a] = data_port_out[8*ln +: 8];
            else
                word[8*ln +: 8] = mem[a];
        end
        data_port_in = word;
        case (cur_pw)
            bus_if_pkg::PORT_16: dsack_n = bus_if_pkg::DSACK_16;
            bus_if_pkg::PORT_8:  dsack_n = bus_if_pkg::DSACK_8;
            default:             dsack_n = bus_if_pkg::DSACK_32;
        endcase
    endtask

    always @(posedge CLK) begin
        #1;
        if (RESET_CPU_I || as_n) begin
            dsack_n = bus_if_pkg::DSACK_NONE;
            acked = 1'b0;
        end else if (dben_n) begin      // Address phase opens a port cycle.
            dsack_n = bus_if_pkg::DSACK_NONE;
            acked = 1'b0;
            wcnt = cur_waits;
            port_cycles++;
            check_bit("ds_n", ds_n, cur_wr);    // Early on reads, late on writes.
        end else if (!acked) begin
            if (wcnt == 0) begin
                respond();
                acked = 1'b1;
            end else begin
                wcnt--;
            end
        end
    end

    task automatic add_entry(bit wr, bus_if_pkg::addr_t adr, bus_if_pkg::op_size_t sz,
                             bus_if_pkg::data_t wdata, bus_if_pkg::port_width_t pw,
                             int waits, bus_if_pkg::data_t exp, int cycles);
        entry_t e;
        e = '{wr, adr, sz, wdata, pw, waits, exp, cycles};
        table_q.push_back(e);
    endtask

    task automatic run_entry(entry_t e, int waits);
        int n;
        logic prev_dben;
        n = (e.sz == bus_if_pkg::OP_LONG) ? 4 : (e.sz == bus_if_pkg::OP_WORD) ? 2 : 1;
        @(posedge CLK);
        #1;
        cur_pw = e.pw;
        cur_wr = e.wr;
        cur_waits = waits;
        port_cycles = 0;
        adr_in = e.adr;
        op_size = e.sz;
        data_from_core = e.wdata;
        rd_req = !e.wr;
        wr_req = e.wr;
        prev_dben = 1'b1;
        @(negedge CLK);
        while (!data_rdy) begin
            prev_dben = dben_n;
            @(negedge CLK);
        end
        check_bit("dben_n before data_rdy", prev_dben, 1'b0);
        check_bit("bus_bsy at data_rdy", bus_bsy, 1'b0);
        check_count("port_cycles", port_cycles, e.cycles);
        if (e.wr) begin
            for (int k = 0; k < n; k++)
                ref_mem[e.adr[5:0] + k] = 8'(e.wdata >> (8 * (n - 1 - k)));
            for (int a = 0; a < 64; a++)
                check_data($sformatf("mem[%0d]", a), {24'h0, mem[a]}, {24'h0, ref_mem[a]});
        end else begin
            check_data("data_to_core", data_to_core, e.exp);
        end
        @(posedge CLK);
        #1;
        check_bit("data_rdy one clock later", data_rdy, 1'b0);
        rd_req = 1'b0;
        wr_req = 1'b0;
    endtask

    // Watchdog, two passes over the table at 40 cycles per entry.
    initial begin
        #1;
        #(4 * 40 * 2 * table_q.size() + 40);
        $display("Timeout: data_rdy never came for the current entry");
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        RESET_CPU_I = 1'b1;
        rd_req = 1'b0;
        wr_req = 1'b0;
        op_size = bus_if_pkg::OP_LONG;
        adr_in = '0;
        data_from_core = '0;
        data_port_in = '0;
        dsack_n = bus_if_pkg::DSACK_NONE;
        cur_pw = bus_if_pkg::PORT_32;
        cur_wr = 1'b0;
        cur_waits = 0;
        port_cycles = 0;
        for (int a = 0; a < 64; a++) begin
            mem[a] = 8'h40 + 8'(a);     // Fill from the whole address.
            ref_mem[a] = mem[a];
        end
        // Reads on the fill pattern, then writes and read-backs.
        add_entry(0, 32'h00, bus_if_pkg::OP_LONG, 0, bus_if_pkg::PORT_32, 0, 32'h40414243, 1);
        add_entry(0, 32'h04, bus_if_pkg::OP_WORD, 0, bus_if_pkg::PORT_32, 1, 32'h00004445, 1);
        add_entry(0, 32'h06, bus_if_pkg::OP_WORD, 0, bus_if_pkg::PORT_32, 0, 32'h00004647, 1);
        add_entry(0, 32'h09, bus_if_pkg::OP_BYTE, 0, bus_if_pkg::PORT_32, 2, 32'h00000049, 1);
        add_entry(0, 32'h01, bus_if_pkg::OP_LONG, 0, bus_if_pkg::PORT_32, 0, 32'h41424344, 2);
        add_entry(0, 32'h01, bus_if_pkg::OP_LONG, 0, bus_if_pkg::PORT_16, 1, 32'h41424344, 3);
        add_entry(0, 32'h03, bus_if_pkg::OP_LONG, 0, bus_if_pkg::PORT_8, 0, 32'h43444546, 4);
        add_entry(0, 32'h0B, bus_if_pkg::OP_WORD, 0, bus_if_pkg::PORT_16, 0, 32'h00004B4C, 2);
        add_entry(0, 32'h0D, bus_if_pkg::OP_WORD, 0, bus_if_pkg::PORT_8, 2, 32'h00004D4E, 2);
        add_entry(0, 32'h0E, bus_if_pkg::OP_LONG, 0, bus_if_pkg::PORT_16, 0, 32'h4E4F5051, 2);
        add_entry(0, 32'h07, bus_if_pkg::OP_WORD, 0, bus_if_pkg::PORT_32, 1, 32'h00004748, 2);
        add_entry(1, 32'h20, bus_if_pkg::OP_LONG, 32'h11223344, bus_if_pkg::PORT_32, 0, 0, 1);
        add_entry(1, 32'h25, bus_if_pkg::OP_LONG, 32'hA1B2C3D4, bus_if_pkg::PORT_16, 1, 0, 3);
        add_entry(1, 32'h2B, bus_if_pkg::OP_WORD, 32'h00005566, bus_if_pkg::PORT_8, 0, 0, 2);
        add_entry(1, 32'h2F, bus_if_pkg::OP_BYTE, 32'h00000077, bus_if_pkg::PORT_16, 2, 0, 1);
        add_entry(1, 32'h31, bus_if_pkg::OP_WORD, 32'h00008899, bus_if_pkg::PORT_32, 0, 0, 1);
        add_entry(1, 32'h33, bus_if_pkg::OP_LONG, 32'hCAFEF00D, bus_if_pkg::PORT_8, 1, 0, 4);
        add_entry(1, 32'h3A, bus_if_pkg::OP_WORD, 32'h0000BEEF, bus_if_pkg::PORT_16, 0, 0, 1);
        add_entry(0, 32'h20, bus_if_pkg::OP_LONG, 0, bus_if_pkg::PORT_8, 0, 32'h11223344, 4);
        add_entry(0, 32'h25, bus_if_pkg::OP_LONG, 0, bus_if_pkg::PORT_32, 1, 32'hA1B2C3D4, 2);
        add_entry(0, 32'h2B, bus_if_pkg::OP_WORD, 0, bus_if_pkg::PORT_16, 0, 32'h00005566, 2);
        add_entry(0, 32'h2F, bus_if_pkg::OP_BYTE, 0, bus_if_pkg::PORT_8, 0, 32'h00000077, 1);
        add_entry(0, 32'h31, bus_if_pkg::OP_WORD, 0, bus_if_pkg::PORT_16, 2, 32'h00008899, 2);
        add_entry(0, 32'h33, bus_if_pkg::OP_LONG, 0, bus_if_pkg::PORT_16, 0, 32'hCAFEF00D, 3);
        add_entry(0, 32'h3A, bus_if_pkg::OP_WORD, 0, bus_if_pkg::PORT_32, 0, 32'h0000BEEF, 1);
        add_entry(0, 32'h3C, bus_if_pkg::OP_LONG, 0, bus_if_pkg::PORT_32, 1, 32'h7C7D7E7F, 1);

        // ----------------------------------------
        // Reset, outputs idle and no cycle without a request.
        // ----------------------------------------
        for (int c = 0; c < 5; c++) begin
            @(posedge CLK);
            #1;
            if (c == 1)
                RESET_CPU_I = 1'b0;     // Released after two rising edges.
            @(negedge CLK);
            check_bit("as_n", as_n, 1'b1);
            check_bit("ds_n", ds_n, 1'b1);
            check_bit("dben_n", dben_n, 1'b1);
            check_bit("rw_n", rw_n, 1'b1);
            check_bit("data_rdy", data_rdy, 1'b0);
            check_bit("bus_bsy", bus_bsy, 1'b0);
            check_bit("data_port_en", data_port_en, 1'b0);
        end

        foreach (table_q[i])
            run_entry(table_q[i], table_q[i].waits);
        foreach (table_q[i])
            run_entry(table_q[i], $unsigned($random(seed)) % 4);  // Random wait states.

        $display("Errors: data=%0d count=%0d bit=%0d", data_errs, count_errs, bit_errs);
        if (data_errs + count_errs + bit_errs == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule
